// File: hw/stepper_drive.sv
`timescale 1ns/1ps
`default_nettype none

`include "turret_defines.svh"

module stepper_drive #(
    parameter int STEP_DIVIDER = `TURRET_STEP_DIVIDER
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  move,
    input  logic                  direction,
    output turret_pkg::position_t position,
    output stepper_pkg::coil_t    coils
);

    localparam int DIV_WIDTH = $clog2(STEP_DIVIDER + 1);

    logic [DIV_WIDTH-1:0] divider;
    logic                 step_due;
    stepper_pkg::phase_t  phase;

    assign step_due = (divider >= DIV_WIDTH'(STEP_DIVIDER));

    // Divider holds at the limit until the motor is allowed to move
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            divider  <= '0;
            position <= '0;
        end
        else if (step_due && move)
        begin
            divider <= '0;
            if (direction)
                position <= position + 1'b1;
            else
                position <= position - 1'b1;
        end
        else if (!step_due)
        begin
            divider <= divider + 1'b1;
        end
    end

    // Phase follows the position, so it never drifts from it
    assign phase = position[2:0];
    assign coils = stepper_pkg::COIL_TABLE[phase];

endmodule

`default_nettype wire

// File: hw/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

    // Index into the eight half-step coil patterns
    typedef logic [2:0] phase_t;

    // One bit per motor coil
    typedef logic [3:0] coil_t;

    // Half-step sequence, one or two coils energized at a time
    parameter coil_t COIL_TABLE [0:7] = '{
        4'b1000,
        4'b1100,
        4'b0100,
        4'b0110,
        4'b0010,
        4'b0011,
        4'b0001,
        4'b1001
    };

endpackage

`default_nettype wire

// File: hw/target_stack.sv
`timescale 1ns/1ps
`default_nettype none

`include "turret_defines.svh"

module target_stack (
    input  logic           clock,
    input  logic           reset,
    target_stack_if.stack  stack
);

    turret_pkg::position_t entries [`TURRET_STACK_DEPTH];

    always_ff @(posedge clock)
    begin
        if (reset || stack.clear)
        begin
            for (int i = 0; i < `TURRET_STACK_DEPTH; i++)
                entries[i] <= `TURRET_EMPTY_TARGET;
        end
        else if (stack.pop)
        begin
            // Shift up, empty mark enters at the bottom
            for (int i = 0; i < `TURRET_STACK_DEPTH - 1; i++)
                entries[i] <= entries[i + 1];
            entries[`TURRET_STACK_DEPTH - 1] <= `TURRET_EMPTY_TARGET;
        end
        else if (stack.push)
        begin
            // Shift down, oldest entry falls off the bottom
            entries[0] <= stack.push_value;
            for (int i = 1; i < `TURRET_STACK_DEPTH; i++)
                entries[i] <= entries[i - 1];
        end
    end

    assign stack.top = entries[0];

endmodule

`default_nettype wire

// File: hw/target_stack_if.sv
`timescale 1ns/1ps
`default_nettype none

interface target_stack_if;

    // Strobes from the controller
    logic push;
    logic pop;

    // Held for the whole return sweep
    logic clear;

    // Angle written on a push, wired from the top-level target port
    turret_pkg::position_t push_value;

    // Nearest pending target
    turret_pkg::position_t top;

    modport controller (
        output push,
        output pop,
        output clear,
        input  top
    );

    modport stack (
        input  push,
        input  pop,
        input  clear,
        input  push_value,
        output top
    );

endinterface

`default_nettype wire

// File: hw/turret_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "turret_defines.svh"

module turret_control #(
    parameter int FIRE_CYCLES = `TURRET_FIRE_CYCLES
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      arm,
    input  logic                      load,
    input  turret_pkg::position_t     position,
    output logic                      move,
    output logic                      direction,
    output logic                      fire,
    output logic                      idle,
    target_stack_if.controller        stack
);

    localparam int TIMER_WIDTH = $clog2(FIRE_CYCLES + 1);

    turret_pkg::turret_state_t state;
    turret_pkg::turret_state_t state_next;
    logic [TIMER_WIDTH-1:0]    fire_timer;
    logic                      fire_done;

    // Last cycle of the fire pulse
    assign fire_done = (fire_timer == TIMER_WIDTH'(FIRE_CYCLES - 1));

    always_comb
    begin
        state_next = state;
        case (state)
            turret_pkg::IDLE:
            begin
                if (arm)
                    state_next = turret_pkg::SCAN;
            end
            turret_pkg::SCAN:
            begin
                if (position >= `TURRET_POS_WIDTH'(`TURRET_MAX_ROT))
                    state_next = turret_pkg::RETURN;
                else if (stack.top < position)
                    state_next = turret_pkg::POP;
            end
            turret_pkg::POP:
            begin
                state_next = turret_pkg::FIRE;
            end
            turret_pkg::FIRE:
            begin
                if (fire_done)
                    state_next = turret_pkg::SCAN;
            end
            turret_pkg::RETURN:
            begin
                if (position < `TURRET_POS_WIDTH'(`TURRET_MIN_ROT))
                    state_next = turret_pkg::IDLE;
            end
            default:
            begin
                state_next = turret_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            state <= turret_pkg::IDLE;
        else
            state <= state_next;
    end

    // Fire timer runs only while firing
    always_ff @(posedge clock)
    begin
        if (reset || state != turret_pkg::FIRE)
            fire_timer <= '0;
        else
            fire_timer <= fire_timer + 1'b1;
    end

    // No step beyond the sweep end while the turn back is pending
    assign move      = ((state == turret_pkg::SCAN)
                        && (position < `TURRET_POS_WIDTH'(`TURRET_MAX_ROT)))
                       || (state == turret_pkg::RETURN);
    assign direction = (state != turret_pkg::RETURN);
    assign fire      = (state == turret_pkg::FIRE);
    assign idle      = (state == turret_pkg::IDLE);

    // Targets can only be loaded while parked
    assign stack.push  = load && (state == turret_pkg::IDLE);
    assign stack.pop   = (state == turret_pkg::POP);
    assign stack.clear = (state == turret_pkg::RETURN);

endmodule

`default_nettype wire

// File: hw/turret_pkg.sv
`default_nettype none

`include "turret_defines.svh"

package turret_pkg;

    // One turret angle in half steps
    typedef logic [`TURRET_POS_WIDTH-1:0] position_t;

    typedef enum logic [2:0] {
        IDLE,
        SCAN,
        POP,
        FIRE,
        RETURN
    } turret_state_t;

endpackage

`default_nettype wire

// File: hw/turret_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "turret_defines.svh"

module turret_top #(
    parameter int STEP_DIVIDER = `TURRET_STEP_DIVIDER,
    parameter int FIRE_CYCLES  = `TURRET_FIRE_CYCLES
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  arm,
    input  logic                  load,
    input  turret_pkg::position_t target,
    output stepper_pkg::coil_t    coils,
    output logic                  fire,
    output turret_pkg::position_t position,
    output logic                  idle
);

    logic move;
    logic direction;

    target_stack_if stack_bus ();

    assign stack_bus.push_value = target;

    target_stack stack_i (
        .clock (clock),
        .reset (reset),
        .stack (stack_bus.stack)
    );

    stepper_drive #(
        .STEP_DIVIDER (STEP_DIVIDER)
    ) stepper_i (
        .clock     (clock),
        .reset     (reset),
        .move      (move),
        .direction (direction),
        .position  (position),
        .coils     (coils)
    );

    turret_control #(
        .FIRE_CYCLES (FIRE_CYCLES)
    ) control_i (
        .clock     (clock),
        .reset     (reset),
        .arm       (arm),
        .load      (load),
        .position  (position),
        .move      (move),
        .direction (direction),
        .fire      (fire),
        .idle      (idle),
        .stack     (stack_bus.controller)
    );

endmodule

`default_nettype wire

// File: include/turret_defines.svh
`ifndef TURRET_DEFINES_SVH
`define TURRET_DEFINES_SVH

// Angle word and stack geometry
`define TURRET_POS_WIDTH 11
`define TURRET_STACK_DEPTH 8

// All ones marks a slot with no target
`define TURRET_EMPTY_TARGET {`TURRET_POS_WIDTH{1'b1}}

// Sweep limits in half steps
`define TURRET_MAX_ROT 2000
`define TURRET_MIN_ROT 10

// Default timing for a 50 MHz clock
`define TURRET_STEP_DIVIDER 50000
`define TURRET_FIRE_CYCLES 25000000

`endif

// File: verif/turret_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "turret_defines.svh"

module turret_checker #(
    parameter int FIRE_CYCLES = 6
) (
    input logic                  clock,
    input logic                  reset,
    input logic                  load,
    input turret_pkg::position_t target,
    input stepper_pkg::coil_t    coils,
    input logic                  fire,
    input logic                  idle,
    input turret_pkg::position_t position
);

    // Reference stack, entry 0 is the top
    turret_pkg::position_t model [$];

    turret_pkg::position_t last_position;
    logic last_reset;
    logic last_fire;
    logic last_idle;
    logic reached_max;
    logic returning;
    logic pop_due;
    int   fire_length;
    int   fires;
    int   loads;
    int   test_errors;
    int   error_count = 0;
    int   sweep_count = 0;

    function automatic stepper_pkg::coil_t expected_coils(input logic [2:0] phase);
        logic [1:0] lead;
        logic [1:0] trail;
        lead  = phase[2:1];
        trail = phase[2:1] + phase[0];
        // Odd phases energize two neighbouring coils
        return (4'b1000 >> lead) | (4'b1000 >> trail);
    endfunction

    function automatic turret_pkg::position_t model_top();
        if (model.size() == 0)
            return `TURRET_EMPTY_TARGET;
        return model[0];
    endfunction

    task automatic report(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    // Values read here are the ones held during the cycle before this edge
    always @(posedge clock)
    begin
        if (reset)
        begin
            model.delete();
            reached_max = 1'b0;
            returning   = 1'b0;
            pop_due     = 1'b0;
            fire_length = 0;
            fires       = 0;
            loads       = 0;
            test_errors = 0;
        end
        else
        begin
            if (coils !== expected_coils(position[2:0]))
                report($sformatf("coils %b at position %0d", coils, position));
            if (last_reset)
            begin
                if (position !== '0 || coils !== 4'b1000 || fire !== 1'b0 || idle !== 1'b1)
                    report("outputs after reset are not the reset values");
                $display("reset values: %0d errors", test_errors);
                test_errors = 0;
            end
            else if (position != last_position)
            begin
                if (position == last_position + 1'b1)
                begin
                    if (last_idle || last_fire || reached_max)
                        report($sformatf("position rose to %0d outside a sweep", position));
                    // Passing a lower target must start a pop on the same edge
                    if (model_top() < last_position)
                    begin
                        if (pop_due)
                            report($sformatf("target %0d passed without firing", model_top()));
                        pop_due = 1'b1;
                    end
                end
                else if (position == last_position - 1'b1)
                begin
                    if (!reached_max || last_fire)
                        report($sformatf("position fell to %0d before the sweep end", position));
                    if (!returning && pop_due)
                        report("sweep turned back with a target still due");
                    returning = 1'b1;
                end
                else
                    report($sformatf("position jumped from %0d to %0d", last_position, position));
            end
            if (position == `TURRET_MAX_ROT)
                reached_max = 1'b1;

            if (fire && !last_fire)
            begin
                if (returning)
                    report("fire during the return sweep");
                if (model_top() >= position)
                    report($sformatf("fire at %0d with top target %0d", position, model_top()));
                if (model.size() > 0)
                    model.delete(0);
                pop_due = 1'b0;
                fires++;
            end
            if (fire)
                fire_length++;
            else if (last_fire)
            begin
                if (fire_length != FIRE_CYCLES)
                    report($sformatf("fire lasted %0d cycles", fire_length));
                fire_length = 0;
            end

            if (idle && !last_idle && !last_reset)
            begin
                if (!returning || position >= `TURRET_MIN_ROT)
                    report($sformatf("sweep ended at %0d without a full return", position));
                sweep_count++;
                $display("test %0d: %0d loads, %0d fires, %0d errors",
                         sweep_count, loads, fires, test_errors);
                model.delete();
                reached_max = 1'b0;
                returning   = 1'b0;
                pop_due     = 1'b0;
                loads       = 0;
                fires       = 0;
                test_errors = 0;
            end

            // Ninth push drops the oldest entry
            if (load && idle)
            begin
                model.push_front(target);
                if (model.size() > `TURRET_STACK_DEPTH)
                    model.delete(model.size() - 1);
                loads++;
            end
        end
        last_reset    = reset;
        last_fire     = fire;
        last_idle     = idle;
        last_position = position;
    end

endmodule

`default_nettype wire

// File: verif/turret_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "turret_defines.svh"

module turret_sva (
    input logic                  clock,
    input logic                  reset,
    input logic                  arm,
    input logic                  load,
    input logic                  fire,
    input logic                  idle,
    input turret_pkg::position_t position
);

    int failure_count = 0;

    // Motor is stopped for the whole fire pulse
    assert property (@(posedge clock) disable iff (reset) fire |=> $stable(position))
    else
    begin
        failure_count++;
        $error("position changed while firing");
    end

    // A parked turret never steps
    assert property (@(posedge clock) disable iff (reset) idle |=> $stable(position))
    else
    begin
        failure_count++;
        $error("position changed while the controller is idle");
    end

    // A stray load or arm never parks the turret before the return limit
    assert property (@(posedge clock) disable iff (reset)
        ((load || arm) && !idle && position >= `TURRET_MIN_ROT) |=> !idle)
    else
    begin
        failure_count++;
        $error("load or arm outside idle ended the sweep early");
    end

endmodule

`default_nettype wire

// File: verif/turret_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "turret_defines.svh"

module turret_tb;

    localparam int STEP_DIVIDER = 3;
    localparam int FIRE_CYCLES  = 6;
    localparam int NUM_TESTS    = 6;
    // Out and back at one step per divider period, eight fires and some slack per test
    localparam int CYCLE_LIMIT  = NUM_TESTS * (2 * `TURRET_MAX_ROT * (STEP_DIVIDER + 1)
                                  + 8 * (FIRE_CYCLES + 2) + 64) + 100;

    logic                  clock;
    logic                  reset;
    logic                  arm;
    logic                  load;
    turret_pkg::position_t target;
    stepper_pkg::coil_t    coils;
    logic                  fire;
    turret_pkg::position_t position;
    logic                  idle;
    integer                seed;
    int                    cycle_count;
    int                    load_count;

    turret_top #(
        .STEP_DIVIDER (STEP_DIVIDER),
        .FIRE_CYCLES  (FIRE_CYCLES)
    ) dut_i (
        .clock    (clock),
        .reset    (reset),
        .arm      (arm),
        .load     (load),
        .target   (target),
        .coils    (coils),
        .fire     (fire),
        .position (position),
        .idle     (idle)
    );

    turret_checker #(
        .FIRE_CYCLES (FIRE_CYCLES)
    ) checker_i (
        .clock    (clock),
        .reset    (reset),
        .load     (load),
        .target   (target),
        .coils    (coils),
        .fire     (fire),
        .idle     (idle),
        .position (position)
    );

    bind turret_top turret_sva sva_i (
        .clock    (clock),
        .reset    (reset),
        .arm      (arm),
        .load     (load),
        .fire     (fire),
        .idle     (idle),
        .position (position)
    );

    always #20 clock = ~clock;

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: %0d sweeps did not finish within %0d cycles", NUM_TESTS, CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    // Rare stray loads and arms while busy, which the DUT must ignore
    task automatic run_until_idle();
        logic done;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clock);
            load = 1'b0;
            arm  = 1'b0;
            if (idle)
                done = 1'b1;
            else if (($random(seed) & 63) == 0)
            begin
                load   = 1'b1;
                target = $random(seed);
            end
            else if (($random(seed) & 63) == 1)
                arm = 1'b1;
        end
    endtask

    task automatic load_targets(input int count);
        for (int i = 0; i < count; i++)
        begin
            @(negedge clock);
            load   = 1'b1;
            target = $random(seed);
        end
        @(negedge clock);
        load = 1'b0;
    endtask

    task automatic pulse_arm();
        @(negedge clock);
        arm = 1'b1;
        @(negedge clock);
        arm = 1'b0;
    endtask

    initial
    begin
        clock  = 1'b0;
        reset  = 1'b1;
        arm    = 1'b0;
        load   = 1'b0;
        target = '0;
        seed   = 32'hc229;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int test = 0; test < NUM_TESTS; test++)
        begin
            run_until_idle();
            // Second sweep runs with an empty stack
            if (test == 1)
                load_count = 0;
            else
                load_count = $unsigned($random(seed)) % 12;
            load_targets(load_count);
            pulse_arm();
        end
        run_until_idle();
        repeat (2) @(negedge clock);

        $display("Sweeps: %0d of %0d, checker errors: %0d, assertion failures: %0d",
                 checker_i.sweep_count, NUM_TESTS, checker_i.error_count,
                 dut_i.sva_i.failure_count);
        if (checker_i.sweep_count != NUM_TESTS)
            $display("The number of completed sweeps does not match the number of tests");
        if (checker_i.error_count == 0 && dut_i.sva_i.failure_count == 0
            && checker_i.sweep_count == NUM_TESTS)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hw/turret_pkg.sv
hw/stepper_pkg.sv
hw/target_stack_if.sv
hw/target_stack.sv
hw/stepper_drive.sv
hw/turret_control.sv
hw/turret_top.sv
verif/turret_sva.sv
verif/turret_checker.sv
verif/turret_tb.sv
